// ==== tb.f ====
design/mipsPkg.sv
design/fetchUnit.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/memArbiter.sv
design/unifiedMemory.sv
design/mipsCore.sv
design/mipsSystem.sv
testbench/mipsSystem_checker.sv
testbench/mipsTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f tb.f --top-module mipsTb -o mipsSim \
    && ./obj_dir/mipsSim +verilator+error+limit+100 > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// ==== testbench/mipsTb.sv ====
`timescale 1ns/10ps

module mipsTb import mipsPkg::*; ();

    localparam int          waitLimit = 50;
    localparam logic [31:0] lfsrTaps  = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic        clk;
    logic        rst;
    logic        run;
    memReqT      hostReq;
    logic        hostValid;
    logic        hostReady;
    memRspT      hostRsp;
    logic        hostRspValid;
    logic [31:0] pc;
    instrWordU   instr;
    logic        retire;

    int          valueErrors;
    int          otherErrors;
    int          assertFails;
    logic [31:0] lfsrState;
    logic [31:0] prog[$];         // program image, word i goes to byte address 4*i
    logic [31:0] retirePcs[$];    // pc sampled at each retire pulse
    logic [31:0] retireInstrs[$]; // instr sampled at each retire pulse

    mipsSystem #(.memWords(256)) mipsSystem_inst (
        .clk(clk), .rst(rst), .run(run),
        .hostReq(hostReq), .hostValid(hostValid), .hostReady(hostReady),
        .hostRsp(hostRsp), .hostRspValid(hostRspValid),
        .pc(pc), .instr(instr), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
            val = {val[30:0], lfsrState[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] signExtend(input logic [31:0] v);
        return {{16{v[15]}}, v[15:0]};
    endfunction

    // signs differ means the negative one is smaller, else plain magnitude order
    function automatic logic [31:0] signedLess(input logic [31:0] x, input logic [31:0] y);
        if (x[31] != y[31]) begin
            return {31'd0, x[31]};
        end
        return {31'd0, x < y};
    endfunction

    function automatic logic [31:0] fillValue(input logic [31:0] addr);
        return addr ^ 32'hc3c3_c3c3; // distinct per byte address
    endfunction

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [25:0] target);
        return {opJ, target};
    endfunction

    task automatic compareWord(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error %s: got %h expected %h", name, got, expected);
            valueErrors++;
        end
    endtask

    task automatic hostAccess(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int   cycles;
        logic granted;
        logic responded;
        rdata = '0;
        @(posedge clk);
        hostReq   <= '{addr: addr, write: write, wdata: wdata};
        hostValid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            granted = hostReady;
        end while (!granted && cycles < waitLimit);
        hostValid <= 1'b0;
        if (!granted) begin
            $display("host access to %h was never granted", addr);
            otherErrors++;
        end else begin
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                responded = hostRspValid;
            end while (!responded && cycles < waitLimit);
            if (responded) begin
                rdata = hostRsp.rdata;
            end else begin
                $display("host access to %h got no response", addr);
                otherErrors++;
            end
        end
    endtask

    task automatic hostWrite(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        hostAccess(1'b1, addr, data, unused);
    endtask

    task automatic hostRead(input logic [31:0] addr, output logic [31:0] data);
        hostAccess(1'b0, addr, '0, data);
    endtask

    task automatic fillWords(input logic [31:0] base, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            hostWrite(base + 32'(4 * k), fillValue(base + 32'(4 * k)));
        end
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            hostWrite(32'(4 * i), prog[i]);
        end
    endtask

    task automatic pushSelfLoop();
        prog.push_back(encJ(26'(prog.size()))); // parks the core once the program is done
    endtask

    task automatic restartCore();
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic runUntilRetires(input int count);
        int seen;
        int cycles;
        retirePcs.delete();
        retireInstrs.delete();
        @(posedge clk);
        run <= 1'b1;
        seen = 0;
        cycles = 0;
        while (seen < count && cycles < count * 40 + 100) begin
            @(posedge clk);
            cycles++;
            if (retire) begin
                retirePcs.push_back(pc);
                retireInstrs.push_back(instr);
                seen++;
            end
        end
        run <= 1'b0;
        if (seen < count) begin
            $display("only %0d of %0d instructions retired in time", seen, count);
            otherErrors++;
        end
    endtask

    task automatic buildLoadStore(input logic [15:0] val, input logic [15:0] base);
        prog.delete();
        prog.push_back(encI(opAddi, 5'd1, 5'd0, val));
        prog.push_back(encI(opSw, 5'd1, 5'd0, base));
        prog.push_back(encI(opLw, 5'd2, 5'd0, base));
        prog.push_back(encI(opAddi, 5'd3, 5'd2, 16'd1));
        prog.push_back(encI(opSw, 5'd3, 5'd0, base + 16'd4));
        pushSelfLoop();
    endtask

    task automatic checkLoadStore(input logic [31:0] val, input logic [31:0] base);
        logic [31:0] got;
        hostRead(base, got);
        compareWord($sformatf("hostRsp.rdata at %h", base), got, signExtend(val));
        hostRead(base + 32'd4, got);
        compareWord($sformatf("hostRsp.rdata at %h", base + 32'd4), got,
                    signExtend(val) + 32'd1);
    endtask

    task automatic memRoundTrip();
        logic [31:0] shadow [256];
        logic [31:0] addrs[$];
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        int          k;
        for (k = 0; k < 26; k++) begin
            if (k == 24) begin
                addr = 32'h0000_0410; // aliases word 4 of the 256-word memory
            end else if (k == 25) begin
                addr = 32'h0000_0010;
            end else begin
                addr = randBits(12) << 2; // upper index bits wrap
            end
            data = randBits(32);
            shadow[addr[9:2]] = data;
            addrs.push_back(addr);
            hostWrite(addr, data);
        end
        for (k = 0; k < addrs.size(); k++) begin
            hostRead(addrs[k], got);
            compareWord($sformatf("hostRsp.rdata at %h", addrs[k]), got,
                        shadow[addrs[k][9:2]]);
        end
    endtask

    task automatic arithmeticProgram();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [31:0] expected [7];
        logic [4:0]  storeRegs [7];
        int          k;
        a = signExtend(randBits(16));
        b = signExtend(randBits(16));
        storeRegs = '{5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd0};
        expected  = '{a + b, a - b, a & b, a | b,
                      signedLess(a, b),
                      signedLess(b, a),
                      32'd0};
        restartCore();
        fillWords(32'h200, 7);
        prog.delete();
        prog.push_back(encI(opAddi, 5'd1, 5'd0, a[15:0]));
        prog.push_back(encI(opAddi, 5'd2, 5'd0, b[15:0]));
        prog.push_back(encR(fnAdd, 5'd3, 5'd1, 5'd2));
        prog.push_back(encR(fnSub, 5'd4, 5'd1, 5'd2));
        prog.push_back(encR(fnAnd, 5'd5, 5'd1, 5'd2));
        prog.push_back(encR(fnOr, 5'd6, 5'd1, 5'd2));
        prog.push_back(encR(fnSlt, 5'd7, 5'd1, 5'd2));
        prog.push_back(encR(fnSlt, 5'd8, 5'd2, 5'd1));
        prog.push_back(encR(fnAdd, 5'd0, 5'd1, 5'd2)); // $zero must stay 0
        for (k = 0; k < 7; k++) begin
            prog.push_back(encI(opSw, storeRegs[k], 5'd0, 16'(32'h200 + 4 * k)));
        end
        pushSelfLoop();
        loadProgram();
        runUntilRetires(prog.size() - 1);
        for (k = 0; k < 7; k++) begin
            hostRead(32'h200 + 32'(4 * k), got);
            compareWord($sformatf("hostRsp.rdata at %h", 32'h200 + 32'(4 * k)), got,
                        expected[k]);
        end
    endtask

    task automatic loadStoreProgram();
        logic [31:0] val;
        val = randBits(16);
        restartCore();
        fillWords(32'h240, 2);
        buildLoadStore(val[15:0], 16'h0240);
        loadProgram();
        runUntilRetires(5);
        checkLoadStore(val, 32'h240);
    endtask

    task automatic controlFlowProgram();
        logic [31:0] expPcs [7];
        logic [31:0] got;
        int          k;
        expPcs = '{32'h00, 32'h04, 32'h08,
                   32'h08 + 32'd4 + (32'd2 << 2),    // beq taken
                   32'h14 + 32'd4, 32'h18 + 32'd4,   // beq not taken, then j
                   {4'h0, 26'd9, 2'b00}};
        restartCore();
        fillWords(32'h280, 4);
        prog.delete();
        prog.push_back(encI(opAddi, 5'd1, 5'd0, 16'd5));
        prog.push_back(encI(opAddi, 5'd2, 5'd0, 16'd5));
        prog.push_back(encI(opBeq, 5'd2, 5'd1, 16'd2));
        prog.push_back(encI(opSw, 5'd1, 5'd0, 16'h0280)); // skipped
        prog.push_back(encI(opSw, 5'd1, 5'd0, 16'h0284)); // skipped
        prog.push_back(encI(opAddi, 5'd3, 5'd0, 16'd7));
        prog.push_back(encI(opBeq, 5'd3, 5'd1, 16'd1));
        prog.push_back(encJ(26'd9));
        prog.push_back(encI(opSw, 5'd3, 5'd0, 16'h0288)); // jumped over
        prog.push_back(encI(opSw, 5'd3, 5'd0, 16'h028c));
        pushSelfLoop();
        loadProgram();
        runUntilRetires(7);
        if (retirePcs.size() != 7) begin
            $display("error retirePcs.size: got %h expected %h", retirePcs.size(), 7);
            valueErrors++;
        end else begin
            for (k = 0; k < 7; k++) begin
                compareWord($sformatf("pc at retire %0d", k), retirePcs[k], expPcs[k]);
                compareWord($sformatf("instr at retire %0d", k), retireInstrs[k],
                            prog[expPcs[k] >> 2]);
            end
        end
        for (k = 0; k < 3; k++) begin
            hostRead(32'h280 + 32'(4 * k), got);
            compareWord($sformatf("hostRsp.rdata at %h", 32'h280 + 32'(4 * k)), got,
                        fillValue(32'h280 + 32'(4 * k)));
        end
        hostRead(32'h28c, got);
        compareWord("hostRsp.rdata at 0000028c", got, 32'd7);
    endtask

    task automatic runGatingAndArbitration();
        logic [31:0] val;
        logic [31:0] got;
        int          k;
        val = randBits(16);
        restartCore();
        fillWords(32'h300, 4);
        fillWords(32'h2c0, 2);
        buildLoadStore(val[15:0], 16'h02c0);
        loadProgram();
        for (k = 0; k < 40; k++) begin
            @(posedge clk);
            if (retire) begin
                $display("retire pulse seen while run was low");
                otherErrors++;
            end
            compareWord("pc", pc, 32'h0); // reset value, held while run is low
        end
        fork
            runUntilRetires(5);
            begin
                repeat (2) @(posedge clk);
                for (k = 0; k < 4; k++) begin // host traffic while the core runs
                    hostRead(32'h300 + 32'(4 * k), got);
                    compareWord($sformatf("hostRsp.rdata at %h", 32'h300 + 32'(4 * k)),
                                got, fillValue(32'h300 + 32'(4 * k)));
                end
            end
        join
        checkLoadStore(val, 32'h2c0);
    endtask

    initial begin
        rst         = 1'b1;
        run         = 1'b0;
        hostValid   = 1'b0;
        hostReq     = '0;
        valueErrors = 0;
        otherErrors = 0;
        lfsrState   = 32'hd41b;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        memRoundTrip();
        arithmeticProgram();
        loadStoreProgram();
        controlFlowProgram();
        runGatingAndArbitration();
        repeat (2) @(posedge clk);
        assertFails = mipsSystem_inst.mipsSystem_checker_inst.failCount;
        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 valueErrors, otherErrors, assertFails);
        if (valueErrors == 0 && otherErrors == 0 && assertFails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // last resort if a loop above never returns
    initial begin
        #1_000_000;
        $display("simulation did not finish within the time limit");
        $display("test failed");
        $finish;
    end

endmodule

// ==== testbench/mipsSystem_checker.sv ====
`timescale 1ns/10ps

module mipsSystem_checker (
    input logic        clk,
    input logic        rst,
    input logic        hostValid,
    input logic        hostReady,
    input logic        hostRspValid,
    input logic        dataReady,
    input logic        fetchReady,
    input logic        instrValid,
    input logic        retire,
    input logic [31:0] pc
);
    int failCount = 0; // assertion failures so far

    singleGrant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({hostReady, dataReady, fetchReady}))
        else begin
            $error("more than one requester granted");
            failCount++;
        end

    hostRspAfterGrant: assert property (@(posedge clk) disable iff (rst)
        (hostValid && hostReady) |=> hostRspValid)
        else begin
            $error("host response missing one cycle after grant");
            failCount++;
        end

    hostRspOnlyAfterGrant: assert property (@(posedge clk) disable iff (rst)
        hostRspValid |-> $past(hostValid && hostReady))
        else begin
            $error("host response without a grant");
            failCount++;
        end

    retireNeedsInstr: assert property (@(posedge clk) disable iff (rst)
        retire |-> instrValid)
        else begin
            $error("retire without a held instruction");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            failCount++;
        end

endmodule

bind mipsSystem mipsSystem_checker mipsSystem_checker_inst (
    .clk(clk),
    .rst(rst),
    .hostValid(hostValid),
    .hostReady(hostReady),
    .hostRspValid(hostRspValid),
    .dataReady(dataReady),
    .fetchReady(fetchReady),
    .instrValid(mipsCore_inst.instrValid),
    .retire(retire),
    .pc(pc)
);

// ==== design/mipsSystem.sv ====
`timescale 1ns/10ps

module mipsSystem import mipsPkg::*; #(
    parameter int memWords = defMemWords
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  memReqT      hostReq,
    input  logic        hostValid,
    output logic        hostReady,
    output memRspT      hostRsp,
    output logic        hostRspValid,
    output logic [31:0] pc,
    output instrWordU   instr,
    output logic        retire
);
    memReqT fetchReq, dataReq, memReq;
    memRspT fetchRsp, dataRsp, memRsp;
    logic   fetchValid, fetchReady, fetchRspValid;
    logic   dataValid, dataReady, dataRspValid;
    logic   memEn;

    mipsCore mipsCore_inst (
        .clk(clk), .rst(rst), .run(run),
        .fetchReq(fetchReq), .fetchValid(fetchValid), .fetchReady(fetchReady),
        .fetchRsp(fetchRsp), .fetchRspValid(fetchRspValid),
        .dataReq(dataReq), .dataValid(dataValid), .dataReady(dataReady),
        .dataRsp(dataRsp), .dataRspValid(dataRspValid),
        .pc(pc), .instr(instr), .retire(retire)
    );

    memArbiter memArbiter_inst (
        .clk(clk), .rst(rst),
        .hostReq(hostReq), .hostValid(hostValid), .hostReady(hostReady),
        .hostRsp(hostRsp), .hostRspValid(hostRspValid),
        .dataReq(dataReq), .dataValid(dataValid), .dataReady(dataReady),
        .dataRsp(dataRsp), .dataRspValid(dataRspValid),
        .fetchReq(fetchReq), .fetchValid(fetchValid), .fetchReady(fetchReady),
        .fetchRsp(fetchRsp), .fetchRspValid(fetchRspValid),
        .memReq(memReq), .memEn(memEn), .memRsp(memRsp)
    );

    unifiedMemory #(.memWords(memWords)) unifiedMemory_inst (
        .clk(clk), .req(memReq), .en(memEn), .rsp(memRsp)
    );

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    output memReqT      fetchReq,
    output logic        fetchValid,
    input  logic        fetchReady,
    input  memRspT      fetchRsp,
    input  logic        fetchRspValid,
    output memReqT      dataReq,
    output logic        dataValid,
    input  logic        dataReady,
    input  memRspT      dataRsp,
    input  logic        dataRspValid,
    output logic [31:0] pc,
    output instrWordU   instr,
    output logic        retire
);
    localparam logic [1:0] stIdle    = 2'd0;
    localparam logic [1:0] stMemReq  = 2'd1;
    localparam logic [1:0] stMemWait = 2'd2;
    localparam logic [1:0] stExec    = 2'd3;

    logic [1:0]  state;
    logic        instrValid;
    logic [31:0] nextPc;
    logic        regWrite, aluSrc, memToReg, branch, memWrite, memRead, jump, regDst;
    aluOpE       aluOp;
    logic [31:0] readData1, readData2, writeData;
    logic [31:0] aluB, aluResult, loadData;
    logic        aluZero;
    logic [4:0]  destReg;
    logic [31:0] signImm, pcPlus4, branchTarget, jumpTarget;

    fetchUnit fetchUnit_inst (
        .clk(clk), .rst(rst), .run(run),
        .fetchReq(fetchReq), .fetchValid(fetchValid), .fetchReady(fetchReady),
        .fetchRsp(fetchRsp), .fetchRspValid(fetchRspValid),
        .advance(retire), .nextPc(nextPc),
        .pc(pc), .instr(instr), .instrValid(instrValid)
    );

    controlUnit controlUnit_inst (
        .instr(instr), .regWrite(regWrite), .aluSrc(aluSrc), .memToReg(memToReg),
        .branch(branch), .memWrite(memWrite), .memRead(memRead), .jump(jump),
        .regDst(regDst), .aluOp(aluOp)
    );

    assign destReg   = regDst ? instr.rType.rd : instr.rType.rt;
    assign writeData = memToReg ? loadData : aluResult;

    regFile regFile_inst (
        .clk(clk),
        .readAddr1(instr.rType.rs), .readAddr2(instr.rType.rt),
        .writeAddr(destReg), .writeData(writeData),
        .writeEn(retire && regWrite), // only on the retire cycle
        .readData1(readData1), .readData2(readData2)
    );

    assign signImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign aluB    = aluSrc ? signImm : readData2;

    alu alu_inst (
        .op(aluOp), .a(readData1), .b(aluB), .result(aluResult), .zero(aluZero)
    );

    // next pc selection
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr.jType.target, 2'b00};
    assign nextPc       = jump ? jumpTarget : ((branch && aluZero) ? branchTarget : pcPlus4);

    // operands stay put while waiting, nothing writes the regfile meanwhile
    assign dataReq.addr  = aluResult;
    assign dataReq.write = memWrite;
    assign dataReq.wdata = readData2;
    assign dataValid     = (state == stMemReq);

    assign retire = (state == stExec) && run;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (instrValid && run) begin
                        state <= (memRead || memWrite) ? stMemReq : stExec;
                    end
                end
                stMemReq:  if (dataReady) state <= stMemWait;
                stMemWait: if (dataRspValid) state <= stExec; // sw response also lands here
                stExec:    if (run) state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dataRspValid) begin
            loadData <= dataRsp.rdata;
        end
    end

endmodule

// ==== design/unifiedMemory.sv ====
`timescale 1ns/10ps

module unifiedMemory import mipsPkg::*; #(
    parameter int memWords = defMemWords
) (
    input  logic   clk,
    input  memReqT req,
    input  logic   en,
    output memRspT rsp
);
    localparam int idxBits = $clog2(memWords);

    logic [31:0]        mem [memWords];
    logic [idxBits-1:0] idx;

    assign idx = req.addr[idxBits+1:2]; // word index, upper bits wrap

    always_ff @(posedge clk) begin
        if (en) begin
            if (req.write) begin
                mem[idx] <= req.wdata;
            end else begin
                rsp.rdata <= mem[idx]; // valid the cycle after the grant
            end
        end
    end

endmodule

// ==== design/memArbiter.sv ====
`timescale 1ns/10ps

module memArbiter import mipsPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  memReqT hostReq,
    input  logic   hostValid,
    output logic   hostReady,
    output memRspT hostRsp,
    output logic   hostRspValid,
    input  memReqT dataReq,
    input  logic   dataValid,
    output logic   dataReady,
    output memRspT dataRsp,
    output logic   dataRspValid,
    input  memReqT fetchReq,
    input  logic   fetchValid,
    output logic   fetchReady,
    output memRspT fetchRsp,
    output logic   fetchRspValid,
    output memReqT memReq,
    output logic   memEn,
    input  memRspT memRsp
);
    logic [2:0] rspOwner; // one-hot {host, data, fetch} for the response cycle

    // host first, then data, then fetch
    assign hostReady  = hostValid;
    assign dataReady  = dataValid && !hostValid;
    assign fetchReady = fetchValid && !hostValid && !dataValid;

    assign memEn  = hostValid || dataValid || fetchValid;
    assign memReq = hostValid ? hostReq : (dataValid ? dataReq : fetchReq);

    always_ff @(posedge clk) begin
        if (rst) begin
            rspOwner <= '0;
        end else begin
            rspOwner <= {hostReady, dataReady, fetchReady};
        end
    end

    assign hostRspValid  = rspOwner[2];
    assign dataRspValid  = rspOwner[1];
    assign fetchRspValid = rspOwner[0];

    assign hostRsp  = rspOwner[2] ? memRsp : '0;
    assign dataRsp  = rspOwner[1] ? memRsp : '0;
    assign fetchRsp = rspOwner[0] ? memRsp : '0;

endmodule

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu import mipsPkg::*; (
    input  aluOpE       op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // signed compare
            default: result = '0;
        endcase
    end

    assign zero = (result == 32'd0); // beq looks at this after sub

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    input  logic        writeEn,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (writeEn && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // $zero is never stored
        end
    end

    // $zero is hardwired on the read side
    assign readData1 = (readAddr1 == 5'd0) ? 32'd0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? 32'd0 : regs[readAddr2];

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit import mipsPkg::*; (
    input  instrWordU instr,
    output logic      regWrite,
    output logic      aluSrc,
    output logic      memToReg,
    output logic      branch,
    output logic      memWrite,
    output logic      memRead,
    output logic      jump,
    output logic      regDst,
    output aluOpE     aluOp
);

    always_comb begin
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        jump     = 1'b0;
        regDst   = 1'b0;
        aluOp    = aluAdd;

        case (instr.rType.opcode)
            opRType: begin
                regWrite = 1'b1;
                regDst   = 1'b1; // rd is the destination
                case (instr.rType.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: begin
                        regWrite = 1'b0; // unknown funct retires as a no-op
                        regDst   = 1'b0;
                    end
                endcase
            end
            opAddi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opLw: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                memRead  = 1'b1;
            end
            opSw: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: begin
                branch = 1'b1;
                aluOp  = aluSub; // equal when the difference is zero
            end
            opJ:     jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== design/fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    output memReqT      fetchReq,
    output logic        fetchValid,
    input  logic        fetchReady,
    input  memRspT      fetchRsp,
    input  logic        fetchRspValid,
    input  logic        advance,
    input  logic [31:0] nextPc,
    output logic [31:0] pc,
    output instrWordU   instr,
    output logic        instrValid
);
    logic waitRsp; // granted, read data lands next cycle

    assign fetchReq.addr  = pc;
    assign fetchReq.write = 1'b0;
    assign fetchReq.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            fetchValid <= 1'b0;
            waitRsp    <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            if (fetchValid && fetchReady) begin
                fetchValid <= 1'b0;
                waitRsp    <= 1'b1;
            end else if (run && !fetchValid && !waitRsp && !instrValid) begin
                fetchValid <= 1'b1; // new fetch only with the hold register empty
            end
            if (fetchRspValid) begin
                waitRsp    <= 1'b0;
                instrValid <= 1'b1;
            end
            if (advance) begin
                pc         <= nextPc;
                instrValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchRspValid) begin
            instr <= fetchRsp.rdata; // hold until the core retires it
        end
    end

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

    localparam int defMemWords = 256; // memory depth when the top level leaves it alone

    typedef struct packed {
        logic [31:0] addr;  // byte address
        logic        write;
        logic [31:0] wdata;
    } memReqT;

    typedef struct packed {
        logic [31:0] rdata;
    } memRspT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target; // word index within the 256MB region
    } jTypeT;

    // same 32 bits, three views by format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrWordU;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

endpackage
